// File: tetris_params.svh
`ifndef TETRIS_PARAMS_SVH
`define TETRIS_PARAMS_SVH

// playfield geometry
// two spare rows under the floor keep the display word at 22 rows
`define GRID_ROWS 22
`define GRID_COLS 10

// lowest row a piece cell may sit on
`define FLOOR_ROW 19

// seven piece kinds from line through T
`define NUM_KINDS 7

// index widths
`define ROW_W 5
`define KIND_W 3

`endif

// File: tetris_pkg.sv
`default_nettype none

`include "tetris_params.svh"

package tetris_pkg;

    // one grid row with bit c as column c
    typedef logic [`GRID_COLS-1:0] row_t;

    // full grid with index 0 as the top row
    typedef row_t [`GRID_ROWS-1:0] grid_t;

    // piece kind numbered 0 to 6 in spawn order
    typedef logic [`KIND_W-1:0] kind_t;

    // falling piece as its shape and the row of its top cell
    typedef struct packed {
        kind_t                kind;
        logic [`ROW_W-1:0]    top;
    } piece_t;

    // drop controller states
    typedef enum logic [1:0] {
        SPAWN,
        FALLING,
        LANDED
    } fsm_t;

endpackage

`default_nettype wire

// File: piece_source.sv
`timescale 1ns/1ns
`default_nettype none

`include "tetris_params.svh"

module piece_source (
    input  wire logic             clk,
    input  wire logic             reset,
    // one cycle per spawn from the controller
    input  wire logic             spawn_enable,
    output tetris_pkg::kind_t     kind
);

    tetris_pkg::kind_t kind_next;

    // cyclic order where T wraps back to line
    always_comb begin
        if (kind == tetris_pkg::kind_t'(`NUM_KINDS - 1)) begin
            kind_next = '0;
        end else begin
            kind_next = kind + 1'b1;
        end
    end

    // controller samples kind on the same edge this advances
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            kind <= '0;
        end else if (spawn_enable) begin
            kind <= kind_next;
        end
    end

    // counter must stay inside the shape table
    kind_in_range: assert property (
        @(posedge clk) disable iff (reset)
        kind <= tetris_pkg::kind_t'(`NUM_KINDS - 1)
    ) else $error("piece kind %0d out of range", kind);

endmodule

`default_nettype wire

// File: shape_render.sv
`timescale 1ns/1ns
`default_nettype none

`include "tetris_params.svh"

module shape_render (
    input  wire tetris_pkg::piece_t piece,
    output tetris_pkg::grid_t     mask
);

    // shape as four rows starting at the top cell
    tetris_pkg::row_t [3:0] shape;

    // shape table with columns as bit masks
    // col3 = 0x008, col4 = 0x010, col5 = 0x020, col6 = 0x040
    always_comb begin
        shape = '0;
        case (piece.kind)
            // line four high in column 4
            3'd0: shape = {10'h010, 10'h010, 10'h010, 10'h010};
            // square
            3'd1: shape = {10'h000, 10'h000, 10'h030, 10'h030};
            // L with its foot to the right
            3'd2: shape = {10'h000, 10'h030, 10'h010, 10'h010};
            // reverse L with its foot to the left
            3'd3: shape = {10'h000, 10'h030, 10'h020, 10'h020};
            // S
            3'd4: shape = {10'h000, 10'h000, 10'h030, 10'h060};
            // Z
            3'd5: shape = {10'h000, 10'h000, 10'h060, 10'h030};
            // T pointing up
            3'd6: shape = {10'h000, 10'h000, 10'h038, 10'h010};
            default: shape = '0;
        endcase
    end

    // place shape rows at top..top+3
    always_comb begin
        logic [`ROW_W:0] row_idx;

        mask = '0;
        for (int i = 0; i < 4; i++) begin
            // one extra bit so top+3 cannot wrap
            row_idx = {1'b0, piece.top} + (`ROW_W+1)'(i);
            // rows past the grid are dropped
            if (row_idx < (`ROW_W+1)'(`GRID_ROWS)) begin
                mask[row_idx[`ROW_W-1:0]] = shape[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: drop_controller.sv
`timescale 1ns/1ns
`default_nettype none

`include "tetris_params.svh"

module drop_controller (
    input  wire logic             clk,
    input  wire logic             reset,
    // gravity strobe
    input  wire logic             tick,
    // next kind from the piece source
    input  wire tetris_pkg::kind_t kind,
    // permanent cells from the playfield
    input  wire tetris_pkg::grid_t stored,
    output logic                  spawn_enable,
    output logic                  land,
    output logic                  finish,
    output tetris_pkg::grid_t     active
);

    tetris_pkg::fsm_t   state;
    tetris_pkg::piece_t piece;
    tetris_pkg::piece_t piece_below;
    tetris_pkg::grid_t  cur_mask;
    tetris_pkg::grid_t  below_mask;
    logic               blocked;

    // same piece one row lower for the collision probe
    assign piece_below = '{kind: piece.kind, top: piece.top + 1'b1};

    shape_render i_render_cur (
        .piece (piece),
        .mask  (cur_mask)
    );

    shape_render i_render_below (
        .piece (piece_below),
        .mask  (below_mask)
    );

    // move blocked if any cell goes under the floor or hits a stored cell
    assign blocked = (|below_mask[`GRID_ROWS-1:`FLOOR_ROW+1]) |
                     (|(below_mask & stored));

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= tetris_pkg::SPAWN;
            piece <= '0;
        end else begin
            case (state)
                tetris_pkg::SPAWN: begin
                    // source advances on this same edge
                    piece <= '{kind: kind, top: '0};
                    state <= tetris_pkg::FALLING;
                end
                tetris_pkg::FALLING: begin
                    // without a tick the piece holds its row
                    if (tick) begin
                        if (blocked) begin
                            state <= tetris_pkg::LANDED;
                        end else begin
                            piece.top <= piece.top + 1'b1;
                        end
                    end
                end
                tetris_pkg::LANDED: begin
                    state <= tetris_pkg::SPAWN;
                end
                default: begin
                    state <= tetris_pkg::SPAWN;
                end
            endcase
        end
    end

    assign spawn_enable = (state == tetris_pkg::SPAWN);
    // merge strobe and external finish are the same landing cycle
    assign land   = (state == tetris_pkg::LANDED);
    assign finish = (state == tetris_pkg::LANDED);

    // piece stays visible in LANDED since those cells are being merged
    assign active = (state == tetris_pkg::SPAWN) ? '0 : cur_mask;

    // single landing pulse right after a blocked tick
    finish_one_cycle: assert property (
        @(posedge clk) disable iff (reset)
        finish |-> $past(state == tetris_pkg::FALLING && tick && blocked) ##1 !finish
    ) else $error("finish without a blocked tick or longer than one cycle");

    // overlap only possible right after spawning onto stored cells
    no_overlap_falling: assert property (
        @(posedge clk) disable iff (reset)
        (state == tetris_pkg::FALLING && |(active & stored)) |-> piece.top == '0
    ) else $error("falling piece moved into stored cells at row %0d", piece.top);

endmodule

`default_nettype wire

// File: playfield.sv
`timescale 1ns/1ns
`default_nettype none

`include "tetris_params.svh"

module playfield (
    input  wire logic             clk,
    input  wire logic             reset,
    // one cycle merge strobe
    input  wire logic             land,
    // falling piece mask
    input  wire tetris_pkg::grid_t active,
    output tetris_pkg::grid_t     stored,
    output tetris_pkg::grid_t     display
);

    // permanent cells cleared by reset
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            stored <= '0;
        end else if (land) begin
            stored <= stored | active;
        end
    end

    // stored cells plus the falling piece
    // merge is seen here one cycle after land
    assign display = stored | active;

    // landed pieces never reach the spare rows under the floor
    spare_rows_empty: assert property (
        @(posedge clk) disable iff (reset)
        stored[`GRID_ROWS-1:`FLOOR_ROW+1] == '0
    ) else $error("stored cell below the floor row");

endmodule

`default_nettype wire

// File: tetris_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "tetris_params.svh"

module tetris_top (
    input  wire logic             clk,
    input  wire logic             reset,
    // gravity strobe of one cycle per step
    input  wire logic             tick,
    output logic                  spawn_enable,
    // kind of the next piece to spawn
    output tetris_pkg::kind_t     blocktype,
    output tetris_pkg::grid_t     display,
    output logic                  finish
);

    tetris_pkg::kind_t kind;
    tetris_pkg::grid_t active;
    tetris_pkg::grid_t stored;
    logic              land;

    piece_source i_source (
        .clk          (clk),
        .reset        (reset),
        .spawn_enable (spawn_enable),
        .kind         (kind)
    );

    drop_controller i_ctrl (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .kind         (kind),
        .stored       (stored),
        .spawn_enable (spawn_enable),
        .land         (land),
        .finish       (finish),
        .active       (active)
    );

    playfield i_field (
        .clk     (clk),
        .reset   (reset),
        .land    (land),
        .active  (active),
        .stored  (stored),
        .display (display)
    );

    assign blocktype = kind;

endmodule

`default_nettype wire

// File: tb_tetris_checks.svh
`ifndef TB_TETRIS_CHECKS_SVH
`define TB_TETRIS_CHECKS_SVH

// tallies for the closing line
int checks_done = 0;
int value_errors = 0;
int other_errors = 0;

// whole grid compare
task automatic check_grid(input string name, input tetris_pkg::grid_t got,
                          input tetris_pkg::grid_t exp);
    checks_done++;
    if (got !== exp) begin
        value_errors++;
        $display("FAIL %s: got %h expected %h", name, got, exp);
    end
endtask

// piece kind compare
task automatic check_kind(input string name, input tetris_pkg::kind_t got,
                          input tetris_pkg::kind_t exp);
    checks_done++;
    if (got !== exp) begin
        value_errors++;
        $display("FAIL %s: got %h expected %h", name, got, exp);
    end
endtask

// single strobe or level
task automatic check_bit(input string name, input logic got, input logic exp);
    checks_done++;
    if (got !== exp) begin
        value_errors++;
        $display("FAIL %s: got %h expected %h", name, got, exp);
    end
endtask

// polls on falling edges and gives up after limit cycles
task automatic wait_spawn(input int limit);
    int n;
    n = 0;
    while (spawn_enable !== 1'b1 && n < limit) begin
        @(negedge clk);
        n++;
    end
    if (spawn_enable !== 1'b1) begin
        other_errors++;
        $display("spawn_enable did not rise within %0d cycles", limit);
        end_run();
    end
endtask

`endif

// File: tb_tetris.sv
`timescale 1ns/1ns
`default_nettype none

`include "tetris_params.svh"

module tb_tetris;

    logic              clk;
    logic              reset;
    logic              tick;
    logic              spawn_enable;
    tetris_pkg::kind_t blocktype;
    tetris_pkg::grid_t display;
    logic              finish;

    // reference model of settled cells, falling kind and kind due next
    tetris_pkg::grid_t field;
    tetris_pkg::kind_t cur_kind;
    tetris_pkg::kind_t next_kind;

    tetris_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .tick         (tick),
        .spawn_enable (spawn_enable),
        .blocktype    (blocktype),
        .display      (display),
        .finish       (finish)
    );

    `include "tb_tetris_checks.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one byte per cell with row offset in the high nibble and column in the low
    function automatic logic [31:0] cells_of(input tetris_pkg::kind_t k);
        case (k)
            3'd0: return 32'h34_24_14_04;
            3'd1: return 32'h15_14_05_04;
            3'd2: return 32'h25_24_14_04;
            3'd3: return 32'h24_25_15_05;
            3'd4: return 32'h15_14_06_05;
            3'd5: return 32'h16_15_05_04;
            3'd6: return 32'h15_14_13_04;
            default: return 32'h0;
        endcase
    endfunction

    // piece kind drawn with its top cell at row top
    function automatic tetris_pkg::grid_t shape_at(input tetris_pkg::kind_t k, input int top);
        tetris_pkg::grid_t g;
        logic [31:0]       cells;
        logic [7:0]        c;
        int                r;
        g = '0;
        cells = cells_of(k);
        for (int i = 0; i < 4; i++) begin
            c = cells[8*i +: 8];
            r = top + c[7:4];
            if (r < `GRID_ROWS) begin
                g[r][c[3:0]] = 1'b1;
            end
        end
        return g;
    endfunction

    // true when no cell is under the floor or on a settled cell
    function automatic bit fits(input tetris_pkg::kind_t k, input int top);
        logic [31:0] cells;
        logic [7:0]  c;
        int          r;
        cells = cells_of(k);
        for (int i = 0; i < 4; i++) begin
            c = cells[8*i +: 8];
            r = top + c[7:4];
            if (r > `FLOOR_ROW) begin
                return 1'b0;
            end
            if (field[r][c[3:0]]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // spawn order wraps T back to line
    function automatic tetris_pkg::kind_t following(input tetris_pkg::kind_t k);
        if (k == `NUM_KINDS - 1) begin
            return '0;
        end
        return k + 1'b1;
    endfunction

    task automatic end_run;
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks_done, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // ends on a falling edge with reset released and the model cleared
    task automatic apply_reset;
        @(posedge clk);
        reset <= 1'b1;
        tick <= 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        field = '0;
        next_kind = '0;
    endtask

    // random idle gap before a one-cycle tick
    task automatic pulse_tick;
        int gap;
        gap = $urandom_range(5, 0);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        tick <= 1'b1;
        @(posedge clk);
        tick <= 1'b0;
        @(negedge clk);
    endtask

    // SPAWN cycle shows only settled cells before the new piece appears at row 0
    task automatic spawn_next;
        wait_spawn(10);
        check_bit("finish", finish, 1'b0);
        check_grid("display", display, field);
        @(negedge clk);
        cur_kind = next_kind;
        next_kind = following(next_kind);
        check_kind("blocktype", blocktype, next_kind);
        check_grid("display", display, field | shape_at(cur_kind, 0));
    endtask

    // tick until finish and check every step against the model
    task automatic drop_piece(output int n_ticks);
        int top;
        bit landed;
        top = 0;
        landed = 1'b0;
        n_ticks = 0;
        while (!landed && n_ticks < 25) begin
            pulse_tick();
            n_ticks++;
            if (fits(cur_kind, top + 1)) begin
                top++;
                check_bit("finish", finish, 1'b0);
            end else begin
                // LANDED still shows the piece being merged
                check_bit("finish", finish, 1'b1);
            end
            check_grid("display", display, field | shape_at(cur_kind, top));
            landed = (finish === 1'b1);
        end
        if (landed) begin
            field = field | shape_at(cur_kind, top);
        end else begin
            other_errors++;
            $display("piece of kind %0d never landed", cur_kind);
        end
    endtask

    task automatic after_reset;
        check_grid("display", display, '0);
        check_bit("finish", finish, 1'b0);
        spawn_next();
    endtask

    // 16 steps down before the 17th tick lands on the floor
    task automatic line_landing;
        int n;
        drop_piece(n);
        if (n != 17) begin
            other_errors++;
            $display("line landed after %0d ticks instead of 17", n);
        end
        spawn_next();
    endtask

    // square stops on top of the line in rows 14 and 15
    task automatic stacking;
        int n;
        drop_piece(n);
        if (n != 15) begin
            other_errors++;
            $display("square landed after %0d ticks instead of 15", n);
        end
        spawn_next();
    endtask

    task automatic kind_order;
        int n;
        apply_reset();
        repeat (8) begin
            spawn_next();
            drop_piece(n);
        end
    endtask

    // tick high through the SPAWN cycle must not move the new piece
    task automatic ignored_spawn_tick;
        int n;
        apply_reset();
        spawn_next();
        drop_piece(n);
        @(posedge clk);
        tick <= 1'b1;
        @(negedge clk);
        check_bit("spawn_enable", spawn_enable, 1'b1);
        check_grid("display", display, field);
        @(posedge clk);
        tick <= 1'b0;
        @(negedge clk);
        cur_kind = next_kind;
        next_kind = following(next_kind);
        check_kind("blocktype", blocktype, next_kind);
        check_grid("display", display, field | shape_at(cur_kind, 0));
        drop_piece(n);
    endtask

    initial begin
        void'($urandom(32'hded1_e83a));
        reset = 1'b1;
        tick = 1'b0;
        field = '0;
        cur_kind = '0;
        next_kind = '0;
        apply_reset();
        after_reset();
        line_landing();
        stacking();
        kind_order();
        ignored_spawn_tick();
        end_run();
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
tetris_pkg.sv
piece_source.sv
shape_render.sv
drop_controller.sv
playfield.sv
tetris_top.sv
tb_tetris.sv
